//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = fetch_tb
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- common/fetch_pkg.sv
//////////////////////////////////////////////////
// fetch bundle geometry, btb and ras sizes
// and the reset pc
//////////////////////////////////////////////////
`default_nettype none

package fetch_pkg;

  localparam int PC_W         = 64;
  localparam int LANES        = 8;
  localparam int INST_W       = 32;
  localparam int BUNDLE_W     = LANES * INST_W;
  localparam int BUNDLE_BYTES = 32;
  // byte offset bits inside a bundle
  localparam int OFS_W        = 5;
  localparam int POS_W        = 3;

  // btb indexed by pc bits 8..5
  localparam int BTB_ENTRIES  = 16;
  localparam int BTB_IDX_W    = 4;
  localparam int BTB_TAG_W    = PC_W - BTB_IDX_W - OFS_W;

  localparam int RAS_DEPTH    = 8;
  localparam int RAS_PTR_W    = 3;

  localparam logic [PC_W-1:0] RESET_PC = '0;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
//////////////////////////////////////////////////
// instruction field positions, branch opcodes
// and the branch type enum for the fetch decoder
//////////////////////////////////////////////////
`default_nettype none

package isa_pkg;

  //////////////////////////////////////////////////
  // field positions
  //////////////////////////////////////////////////
  localparam int FLD_OPC_HI  = 31;
  localparam int FLD_OPC_LO  = 26;
  localparam int FLD_HINT_HI = 15;
  localparam int FLD_HINT_LO = 14;

  // branch displacement, bits 20..0, in instructions
  localparam int DISP_W = 21;

  //////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////
  localparam logic [5:0] OPC_BR      = 6'h30;
  localparam logic [5:0] OPC_BSR     = 6'h34;
  localparam logic [5:0] OPC_JSR     = 6'h1A;
  localparam logic [5:0] OPC_COND_LO = 6'h38;
  localparam logic [5:0] OPC_COND_HI = 6'h3F;

  // jsr group hint that marks a return
  localparam logic [1:0] JSR_HINT_RET = 2'b10;

  // branch class seen by btb and decoder
  typedef enum logic [2:0] {
    BR_NONE,
    BR_COND,
    BR_UNCOND,
    BR_CALL,
    BR_RET
  } br_type_e;

endpackage

`default_nettype wire

//--- fetch/brdec.sv
//////////////////////////////////////////////////
// f1 branch decoder
// finds the first taken branch of a bundle
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module brdec (
  input  logic [fetch_pkg::PC_W-1:0]      pc_f1_i,
  input  logic [fetch_pkg::BUNDLE_W-1:0]  bundle_i,
  input  logic [fetch_pkg::POS_W-1:0]     first_lane_i,
  input  logic [fetch_pkg::PC_W-1:0]      ras_top_i,
  input  logic                            ras_valid_i,
  output logic                            taken_o,
  output logic [fetch_pkg::POS_W-1:0]     br_pos_o,
  output isa_pkg::br_type_e               br_typ_o,
  output logic [fetch_pkg::PC_W-1:0]      br_tar_o
);

  import isa_pkg::*;
  import fetch_pkg::*;

  br_type_e        lane_typ [LANES];
  logic [PC_W-1:0] lane_tar [LANES];
  logic [LANES-1:0] lane_tkn;

  function automatic br_type_e classify(input logic [INST_W-1:0] inst);
    logic [5:0] opc;
    logic [1:0] hint;
    opc  = inst[FLD_OPC_HI:FLD_OPC_LO];
    hint = inst[FLD_HINT_HI:FLD_HINT_LO];
    if (opc == OPC_BR) return BR_UNCOND;
    if (opc == OPC_BSR) return BR_CALL;
    if (opc >= OPC_COND_LO && opc <= OPC_COND_HI) return BR_COND;
    // other jsr hints are indirect jumps, not predicted
    if (opc == OPC_JSR && hint == JSR_HINT_RET) return BR_RET;
    return BR_NONE;
  endfunction

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    logic [INST_W-1:0] inst;
    logic [PC_W-1:0]   lane_pc;
    logic [PC_W-1:0]   disp_ext;
    logic              in_range;

    assign inst     = bundle_i[g*INST_W +: INST_W];
    assign lane_pc  = {pc_f1_i[PC_W-1:OFS_W], POS_W'(g), 2'b00};
    assign disp_ext = {{(PC_W-DISP_W-2){inst[DISP_W-1]}}, inst[DISP_W-1:0], 2'b00};
    assign in_range = (POS_W'(g) >= first_lane_i);

    assign lane_typ[g] = classify(inst);
    assign lane_tar[g] = lane_pc + PC_W'(4) + disp_ext;

    // static rules, backward conditionals taken
    assign lane_tkn[g] = in_range &&
                         ((lane_typ[g] == BR_UNCOND) ||
                          (lane_typ[g] == BR_CALL) ||
                          (lane_typ[g] == BR_COND && inst[DISP_W-1]) ||
                          (lane_typ[g] == BR_RET && ras_valid_i));
  end

  // walk down so the lowest taken lane wins
  always_comb begin
    taken_o  = 1'b0;
    br_pos_o = '0;
    br_typ_o = BR_NONE;
    br_tar_o = '0;
    for (int i = LANES-1; i >= 0; i--) begin
      if (lane_tkn[i]) begin
        taken_o  = 1'b1;
        br_pos_o = POS_W'(i);
        br_typ_o = lane_typ[i];
        br_tar_o = (lane_typ[i] == BR_RET) ? ras_top_i : lane_tar[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- fetch/btb.sv
//////////////////////////////////////////////////
// direct mapped branch target buffer
// async lookup in f0, write from f1 decode
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module btb (
  input  logic                           clock,
  input  logic                           reset_n,
  // f0 lookup
  input  logic [fetch_pkg::PC_W-1:0]     pc_f0_i,
  output logic                           hit_o,
  output logic [fetch_pkg::POS_W-1:0]    br_pos_o,
  output isa_pkg::br_type_e              br_typ_o,
  output logic [fetch_pkg::PC_W-1:0]     br_tar_o,
  // f1 training
  input  logic                           we_i,
  input  logic [fetch_pkg::PC_W-1:0]     wr_pc_i,
  input  logic [fetch_pkg::POS_W-1:0]    wr_pos_i,
  input  isa_pkg::br_type_e              wr_typ_i,
  input  logic [fetch_pkg::PC_W-1:0]     wr_tar_i
);

  import isa_pkg::*;
  import fetch_pkg::*;

  logic [BTB_ENTRIES-1:0] valid_q;
  logic [BTB_TAG_W-1:0]   tag_q [BTB_ENTRIES];
  logic [POS_W-1:0]       pos_q [BTB_ENTRIES];
  br_type_e               typ_q [BTB_ENTRIES];
  logic [PC_W-1:0]        tar_q [BTB_ENTRIES];

  logic [BTB_IDX_W-1:0]   rd_idx;
  logic [BTB_TAG_W-1:0]   rd_tag;
  logic [BTB_IDX_W-1:0]   wr_idx;
  logic [BTB_TAG_W-1:0]   wr_tag;

  assign rd_idx = pc_f0_i[OFS_W +: BTB_IDX_W];
  assign rd_tag = pc_f0_i[PC_W-1 -: BTB_TAG_W];
  assign wr_idx = wr_pc_i[OFS_W +: BTB_IDX_W];
  assign wr_tag = wr_pc_i[PC_W-1 -: BTB_TAG_W];

  // only taken branches live here, so a hit means taken
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign br_pos_o = pos_q[rd_idx];
  assign br_typ_o = typ_q[rd_idx];
  assign br_tar_o = tar_q[rd_idx];

  // a not-taken write drops the stale entry
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[wr_idx] <= (wr_typ_i != BR_NONE);
    end
  end

  always_ff @(posedge clock) begin
    if (we_i) begin
      tag_q[wr_idx] <= wr_tag;
      pos_q[wr_idx] <= wr_pos_i;
      typ_q[wr_idx] <= wr_typ_i;
      tar_q[wr_idx] <= wr_tar_i;
    end
  end

endmodule

`default_nettype wire

//--- fetch/fetch_unit.sv
//////////////////////////////////////////////////
// two stage fetch datapath
// f0 btb/ras prediction, f1 decode and override,
// d0 bundle register with lane valid mask
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                            clock,
  input  logic                            reset_n,
  input  logic [fetch_pkg::PC_W-1:0]      pc_f0_i,
  input  logic [fetch_pkg::BUNDLE_W-1:0]  icache_data_i,
  input  logic                            icache_stall_i,
  input  logic                            instbuf_full_i,
  input  logic                            flush_i,
  output logic [fetch_pkg::PC_W-1:0]      branch_pc_o,
  output logic                            override_vld_o,
  output logic [fetch_pkg::PC_W-1:0]      override_pc_o,
  output logic                            fill_o,
  output logic [fetch_pkg::PC_W-1:0]      icache_pc_o,
  output logic [fetch_pkg::BUNDLE_W-1:0]  bundle_o,
  output logic [fetch_pkg::PC_W-1:0]      bundle_pc_o,
  output logic [fetch_pkg::LANES-1:0]     bundle_vld_o
);

  import isa_pkg::*;
  import fetch_pkg::*;

  // f0
  logic             btb_hit;
  logic [POS_W-1:0] btb_pos;
  br_type_e         btb_typ;
  logic [PC_W-1:0]  btb_tar;
  logic [POS_W-1:0] first_lane_f0;
  logic             hit_f0;
  logic [PC_W-1:0]  pc_f0_seq;
  logic [PC_W-1:0]  pred_pc_f0;
  logic [PC_W-1:0]  ras_top;
  logic             ras_valid;

  // f1 pipeline state
  logic             vld_f1;
  logic [PC_W-1:0]  pc_f1;
  logic             pred_hit_f1;
  logic [POS_W-1:0] pred_pos_f1;
  logic [PC_W-1:0]  pred_pc_f1;
  logic [POS_W-1:0] first_lane_f1;

  // f1 decode
  logic             dec_taken;
  logic [POS_W-1:0] dec_pos;
  br_type_e         dec_typ;
  logic [PC_W-1:0]  dec_tar;
  logic [PC_W-1:0]  pc_f1_seq;
  logic [PC_W-1:0]  next_pc_f1;
  logic             stall_f1;
  logic             live_f1;
  logic             mismatch;
  logic             upd_f1;
  logic             load_f1;
  logic [LANES-1:0] lane_mask;

  assign fill_o = ~instbuf_full_i | flush_i;

  btb u_btb (
    .clock    (clock),
    .reset_n  (reset_n),
    .pc_f0_i  (pc_f0_i),
    .hit_o    (btb_hit),
    .br_pos_o (btb_pos),
    .br_typ_o (btb_typ),
    .br_tar_o (btb_tar),
    .we_i     (upd_f1 & mismatch),
    .wr_pc_i  (pc_f1),
    .wr_pos_i (dec_pos),
    .wr_typ_i (dec_taken ? dec_typ : BR_NONE),
    .wr_tar_i (dec_tar)
  );

  ras u_ras (
    .clock       (clock),
    .reset_n     (reset_n),
    .flush_i     (flush_i),
    .push_i      (upd_f1 & dec_taken & (dec_typ == BR_CALL)),
    .pop_i       (upd_f1 & dec_taken & (dec_typ == BR_RET)),
    .push_addr_i ({pc_f1[PC_W-1:OFS_W], dec_pos, 2'b00} + PC_W'(4)),
    .top_o       (ras_top),
    .valid_o     (ras_valid)
  );

  brdec u_brdec (
    .pc_f1_i      (pc_f1),
    .bundle_i     (icache_data_i),
    .first_lane_i (first_lane_f1),
    .ras_top_i    (ras_top),
    .ras_valid_i  (ras_valid),
    .taken_o      (dec_taken),
    .br_pos_o     (dec_pos),
    .br_typ_o     (dec_typ),
    .br_tar_o     (dec_tar)
  );

  //////////////////////////////////////////////////
  // f0 next pc
  //////////////////////////////////////////////////
  assign first_lane_f0 = pc_f0_i[OFS_W-1:2];
  // entry for a lane before the entry point does not apply
  assign hit_f0    = btb_hit && (btb_pos >= first_lane_f0);
  assign pc_f0_seq = {pc_f0_i[PC_W-1:OFS_W], OFS_W'(0)} + PC_W'(BUNDLE_BYTES);

  assign pred_pc_f0 = !hit_f0                             ? pc_f0_seq :
                      (btb_typ == BR_RET && ras_valid)    ? ras_top   :
                                                            btb_tar;

  // a stalled f1 refetch keeps the pc where it is
  assign stall_f1    = vld_f1 & icache_stall_i;
  assign branch_pc_o = stall_f1 ? pc_f0_i : pred_pc_f0;

  //////////////////////////////////////////////////
  // f1 check against the f0 prediction
  //////////////////////////////////////////////////
  assign live_f1    = vld_f1 & ~stall_f1 & ~flush_i;
  assign pc_f1_seq  = {pc_f1[PC_W-1:OFS_W], OFS_W'(0)} + PC_W'(BUNDLE_BYTES);
  assign next_pc_f1 = dec_taken ? dec_tar : pc_f1_seq;

  assign mismatch = (dec_taken != pred_hit_f1) ||
                    (dec_taken && (dec_pos != pred_pos_f1)) ||
                    (next_pc_f1 != pred_pc_f1);

  assign override_vld_o = live_f1 & mismatch;
  assign override_pc_o  = next_pc_f1;
  // training happens once, on the edge the bundle moves on
  assign upd_f1  = live_f1 & fill_o;
  assign load_f1 = fill_o & (~stall_f1 | flush_i);

  assign icache_pc_o = {pc_f1[PC_W-1:OFS_W], OFS_W'(0)};

  // lanes from the entry point through the taken branch
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      lane_mask[i] = (POS_W'(i) >= first_lane_f1) && (!dec_taken || POS_W'(i) <= dec_pos);
    end
  end

  //////////////////////////////////////////////////
  // f0 to f1 registers
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      vld_f1        <= 1'b0;
      pc_f1         <= RESET_PC;
      pred_hit_f1   <= 1'b0;
      pred_pos_f1   <= '0;
      pred_pc_f1    <= '0;
      first_lane_f1 <= '0;
    end else if (load_f1) begin
      // squash the f0 bundle behind a flush or override
      vld_f1        <= ~flush_i & ~override_vld_o;
      pc_f1         <= pc_f0_i;
      pred_hit_f1   <= hit_f0;
      pred_pos_f1   <= btb_pos;
      pred_pc_f1    <= pred_pc_f0;
      first_lane_f1 <= first_lane_f0;
    end
  end

  //////////////////////////////////////////////////
  // f1 to d0 registers
  //////////////////////////////////////////////////
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      bundle_vld_o <= '0;
    end else if (fill_o) begin
      bundle_vld_o <= live_f1 ? lane_mask : '0;
    end
  end

  always_ff @(posedge clock) begin
    if (fill_o) begin
      bundle_o    <= icache_data_i;
      bundle_pc_o <= icache_pc_o;
    end
  end

endmodule

`default_nettype wire

//--- fetch/ras.sv
//////////////////////////////////////////////////
// circular return address stack
// push and pop from f1, cleared on flush
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ras (
  input  logic                        clock,
  input  logic                        reset_n,
  input  logic                        flush_i,
  input  logic                        push_i,
  input  logic                        pop_i,
  input  logic [fetch_pkg::PC_W-1:0]  push_addr_i,
  output logic [fetch_pkg::PC_W-1:0]  top_o,
  output logic                        valid_o
);

  import fetch_pkg::*;

  logic [PC_W-1:0]      stack_q [RAS_DEPTH];
  logic [RAS_PTR_W-1:0] top_q;
  logic [RAS_PTR_W-1:0] push_ptr;
  // occupancy, 0 to RAS_DEPTH
  logic [RAS_PTR_W:0]   count_q;

  assign push_ptr = top_q + 1'b1;
  assign top_o    = stack_q[top_q];
  assign valid_o  = (count_q != '0);

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      top_q   <= '0;
      count_q <= '0;
    end else if (push_i) begin
      top_q <= push_ptr;
      // full stack wraps onto the oldest entry
      if (count_q != (RAS_PTR_W+1)'(RAS_DEPTH)) begin
        count_q <= count_q + 1'b1;
      end
    end else if (pop_i && valid_o) begin
      top_q   <= top_q - 1'b1;
      count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (push_i && !flush_i) begin
      stack_q[push_ptr] <= push_addr_i;
    end
  end

endmodule

`default_nettype wire

//--- sources.f
common/isa_pkg.sv
common/fetch_pkg.sv
fetch/btb.sv
fetch/ras.sv
fetch/brdec.sv
fetch/fetch_unit.sv
verilog/pc_gen.sv
verilog/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

//--- testbench/fetch_checker.sv
//////////////////////////////////////////////////
// fetch testbench checker
// records accepted lanes of the d0 bundle and
// compares them with the expected stream
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
  input  logic                            clock,
  input  logic                            reset_n,
  input  logic                            instbuf_full_i,
  input  logic [fetch_pkg::BUNDLE_W-1:0]  bundle_i,
  input  logic [fetch_pkg::PC_W-1:0]      bundle_pc_i,
  input  logic [fetch_pkg::LANES-1:0]     bundle_vld_i
);

  import fetch_pkg::*;

  logic [PC_W-1:0]   exp_pc [$];
  logic [INST_W-1:0] exp_word [$];
  string             test_name;
  bit                armed;
  int                checked_cnt;
  int                error_cnt;

  initial begin
    armed       = 1'b0;
    checked_cnt = 0;
    error_cnt   = 0;
    test_name   = "none";
  end

  task automatic stop_compare();
    armed = 1'b0;
  endtask

  task automatic begin_test(input string name);
    exp_pc.delete();
    exp_word.delete();
    test_name   = name;
    checked_cnt = 0;
    armed       = 1'b1;
  endtask

  task automatic add_expect(input logic [PC_W-1:0] pc, input logic [INST_W-1:0] word);
    exp_pc.push_back(pc);
    exp_word.push_back(word);
  endtask

  // outputs are stable at the falling edge, ahead of the accepting edge
  always @(negedge clock) begin
    logic [PC_W-1:0]   lane_pc;
    logic [INST_W-1:0] lane_word;
    if (reset_n && armed && !instbuf_full_i && bundle_vld_i != '0) begin
      for (int i = 0; i < LANES; i++) begin
        if (bundle_vld_i[i] && exp_pc.size() > 0) begin
          lane_pc   = bundle_pc_i + 64'(4 * i);
          lane_word = bundle_i[i*INST_W +: INST_W];
          if (lane_pc != exp_pc[0]) begin
            $display("** Error %s: lane pc expected %h actual %h",
                     test_name, exp_pc[0], lane_pc);
            error_cnt++;
          end else if (lane_word != exp_word[0]) begin
            $display("** Error %s: word at %h expected %h actual %h",
                     test_name, lane_pc, exp_word[0], lane_word);
            error_cnt++;
          end
          void'(exp_pc.pop_front());
          void'(exp_word.pop_front());
          checked_cnt++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
//////////////////////////////////////////////////
// fetch unit testbench
// clock, reset, program rom cache model,
// test table loop and reference stream walk
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  import isa_pkg::*;
  import fetch_pkg::*;

  typedef struct {
    string           name;
    logic [PC_W-1:0] pc;
    int              img;
    int              n;
    bit              stall_en;
    bit              full_en;
    int              steady;
  } row_t;

  logic                clock;
  logic                reset_n;
  logic                flush_i;
  logic [PC_W-1:0]     flush_pc_i;
  logic                instbuf_full_i;
  logic [BUNDLE_W-1:0] icache_data_i;
  logic                icache_stall_i;
  logic [PC_W-1:0]     icache_pc_o;
  logic [BUNDLE_W-1:0] bundle_o;
  logic [PC_W-1:0]     bundle_pc_o;
  logic [LANES-1:0]    bundle_vld_o;

  row_t tbl [8];
  int   cur_img;
  bit   cur_stall;
  bit   cur_full;
  int   fail_cnt;
  int   timeout_cnt;

  fetch_top UUT (
    .clock          (clock),
    .reset_n        (reset_n),
    .flush_i        (flush_i),
    .flush_pc_i     (flush_pc_i),
    .instbuf_full_i (instbuf_full_i),
    .icache_data_i  (icache_data_i),
    .icache_stall_i (icache_stall_i),
    .icache_pc_o    (icache_pc_o),
    .bundle_o       (bundle_o),
    .bundle_pc_o    (bundle_pc_o),
    .bundle_vld_o   (bundle_vld_o)
  );

  fetch_checker u_chk (
    .clock          (clock),
    .reset_n        (reset_n),
    .instbuf_full_i (instbuf_full_i),
    .bundle_i       (bundle_o),
    .bundle_pc_i    (bundle_pc_o),
    .bundle_vld_i   (bundle_vld_o)
  );

  always #4 clock = ~clock;

  function automatic logic [31:0] branch_word(input logic [5:0] opc, input int disp);
    return {opc, 5'd0, disp[20:0]};
  endfunction

  //////////////////////////////////////////////////
  // program images
  //////////////////////////////////////////////////
  function automatic logic [31:0] rom_word(input int img, input logic [PC_W-1:0] a);
    logic [31:0] w;
    // plain alu op unique to each word address
    w = {6'h11, a[27:2] ^ a[53:28] ^ {16'd0, a[63:54]}};
    if (img == 1) begin
      if (a == 64'h20C) w = branch_word(OPC_BR, 'h7C);
      if (a == 64'h41C) w = branch_word(6'h39, 5);
      if (a == 64'h450) w = branch_word(6'h3B, -19);
    end else if (img == 2) begin
      if (a == 64'h108) w = branch_word(OPC_BSR, 'h7D);
      if (a == 64'h120) w = branch_word(OPC_BR, -9);
      if (a == 64'h310) w = branch_word(OPC_BSR, 'h7B);
      if (a == 64'h318 || a == 64'h50C || a == 64'h608) begin
        w = {OPC_JSR, 10'd0, JSR_HINT_RET, 14'd0};
      end
    end
    return w;
  endfunction

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      icache_data_i[i*INST_W +: INST_W] = rom_word(cur_img, icache_pc_o + 64'(4 * i));
    end
  end

  // reference walk with static prediction and its own return stack
  task automatic load_reference(input int img, input logic [PC_W-1:0] start, input int n);
    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] tgt;
    logic [PC_W-1:0] stack [8];
    logic [31:0]     w;
    int              depth;
    depth = 0;
    pc    = start;
    for (int k = 0; k < n; k++) begin
      w = rom_word(img, pc);
      u_chk.add_expect(pc, w);
      tgt = pc + 64'd4 + {{41{w[20]}}, w[20:0], 2'b00};
      if (w[31:26] == OPC_BR) begin
        pc = tgt;
      end else if (w[31:26] == OPC_BSR) begin
        stack[depth % 8] = pc + 64'd4;
        depth++;
        pc = tgt;
      end else if (w[31:26] >= OPC_COND_LO && w[31:26] <= OPC_COND_HI && w[20]) begin
        pc = tgt;
      end else if (w[31:26] == OPC_JSR && w[15:14] == JSR_HINT_RET && depth > 0) begin
        depth--;
        pc = stack[depth % 8];
      end else begin
        pc = pc + 64'd4;
      end
    end
  endtask

  // random back-pressure and cache stalls
  initial begin
    void'($urandom(32'h00fa_4aab));
    forever begin
      @(posedge clock);
      #1;
      icache_stall_i = cur_stall && ($urandom % 4 == 0);
      instbuf_full_i = cur_full && ($urandom % 3 == 0);
    end
  end

  initial begin
    int cycles;
    int errs_before;
    int gaps;
    tbl[0] = '{"straight", 64'h100, 0, 64, 1'b0, 1'b0, 0};
    tbl[1] = '{"branch_loop", 64'h200, 1, 120, 1'b0, 1'b0, 12};
    tbl[2] = '{"unaligned", 64'h404, 1, 40, 1'b0, 1'b0, 0};
    tbl[3] = '{"flush_mid_loop", 64'h410, 1, 60, 1'b0, 1'b0, 0};
    tbl[4] = '{"calls", 64'h100, 2, 100, 1'b0, 1'b0, 0};
    tbl[5] = '{"ret_empty", 64'h600, 2, 30, 1'b0, 1'b0, 0};
    tbl[6] = '{"random_loop", 64'h200, 1, 200, 1'b1, 1'b1, 0};
    tbl[7] = '{"random_calls", 64'h100, 2, 200, 1'b1, 1'b1, 0};
    clock          = 1'b0;
    reset_n        = 1'b0;
    flush_i        = 1'b0;
    flush_pc_i     = '0;
    instbuf_full_i = 1'b0;
    icache_stall_i = 1'b0;
    cur_img        = 0;
    cur_stall      = 1'b0;
    cur_full       = 1'b0;
    fail_cnt       = 0;
    timeout_cnt    = 0;
    repeat (10) @(posedge clock);
    #1;
    reset_n = 1'b1;

    foreach (tbl[t]) begin
      @(posedge clock);
      #1;
      // redirect by flush and stop comparing the older lanes
      u_chk.stop_compare();
      cur_img    = tbl[t].img;
      cur_stall  = tbl[t].stall_en;
      cur_full   = tbl[t].full_en;
      flush_i    = 1'b1;
      flush_pc_i = tbl[t].pc;
      @(posedge clock);
      #1;
      flush_i     = 1'b0;
      errs_before = u_chk.error_cnt;
      u_chk.begin_test(tbl[t].name);
      load_reference(tbl[t].img, tbl[t].pc, tbl[t].n);
      cycles = 0;
      while (u_chk.checked_cnt < tbl[t].n && cycles < tbl[t].n * 8 + 200) begin
        @(posedge clock);
        cycles++;
      end
      // a loop trained in the btb delivers a bundle every cycle
      gaps = 0;
      for (int c = 0; c < tbl[t].steady; c++) begin
        @(negedge clock);
        if (bundle_vld_o == '0) begin
          gaps++;
        end
      end
      if (u_chk.checked_cnt < tbl[t].n) begin
        $display("test %s timed out: only %0d of %0d lanes arrived",
                 tbl[t].name, u_chk.checked_cnt, tbl[t].n);
        timeout_cnt++;
        fail_cnt++;
      end else if (u_chk.error_cnt != errs_before) begin
        $display("test %s failed with %0d errors", tbl[t].name,
                 u_chk.error_cnt - errs_before);
        fail_cnt++;
      end else if (gaps != 0) begin
        $display("test %s failed: %0d empty bundle cycles in a trained loop",
                 tbl[t].name, gaps);
        fail_cnt++;
      end else begin
        $display("test %s passed, %0d lanes", tbl[t].name, tbl[t].n);
      end
    end

    $display("tests %0d, failed %0d, lane errors %0d, timeouts %0d",
             8, fail_cnt, u_chk.error_cnt, timeout_cnt);
    if (fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/fetch_top.sv
//////////////////////////////////////////////////
// instruction fetch top level
// pc generator and two stage fetch unit
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                            clock,
  input  logic                            reset_n,
  // retire redirect
  input  logic                            flush_i,
  input  logic [fetch_pkg::PC_W-1:0]      flush_pc_i,
  // instruction buffer
  input  logic                            instbuf_full_i,
  // instruction cache
  input  logic [fetch_pkg::BUNDLE_W-1:0]  icache_data_i,
  input  logic                            icache_stall_i,
  output logic [fetch_pkg::PC_W-1:0]      icache_pc_o,
  // d0 bundle
  output logic [fetch_pkg::BUNDLE_W-1:0]  bundle_o,
  output logic [fetch_pkg::PC_W-1:0]      bundle_pc_o,
  output logic [fetch_pkg::LANES-1:0]     bundle_vld_o
);

  import fetch_pkg::*;

  logic [PC_W-1:0] pc_f0;
  logic [PC_W-1:0] branch_pc;
  logic            override_vld;
  logic [PC_W-1:0] override_pc;
  logic            fill;

  pc_gen u_pc_gen (
    .clock          (clock),
    .reset_n        (reset_n),
    .flush_i        (flush_i),
    .flush_pc_i     (flush_pc_i),
    .override_vld_i (override_vld),
    .override_pc_i  (override_pc),
    .branch_pc_i    (branch_pc),
    .fill_i         (fill),
    .pc_f0_o        (pc_f0)
  );

  fetch_unit u_fetch_unit (
    .clock          (clock),
    .reset_n        (reset_n),
    .pc_f0_i        (pc_f0),
    .icache_data_i  (icache_data_i),
    .icache_stall_i (icache_stall_i),
    .instbuf_full_i (instbuf_full_i),
    .flush_i        (flush_i),
    .branch_pc_o    (branch_pc),
    .override_vld_o (override_vld),
    .override_pc_o  (override_pc),
    .fill_o         (fill),
    .icache_pc_o    (icache_pc_o),
    .bundle_o       (bundle_o),
    .bundle_pc_o    (bundle_pc_o),
    .bundle_vld_o   (bundle_vld_o)
  );

endmodule

`default_nettype wire

//--- verilog/pc_gen.sv
//////////////////////////////////////////////////
// fetch pc register
// flush, then override, then predicted pc
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
  input  logic                        clock,
  input  logic                        reset_n,
  input  logic                        flush_i,
  input  logic [fetch_pkg::PC_W-1:0]  flush_pc_i,
  input  logic                        override_vld_i,
  input  logic [fetch_pkg::PC_W-1:0]  override_pc_i,
  input  logic [fetch_pkg::PC_W-1:0]  branch_pc_i,
  input  logic                        fill_i,
  output logic [fetch_pkg::PC_W-1:0]  pc_f0_o
);

  import fetch_pkg::*;

  logic [PC_W-1:0] pc_next;

  always_comb begin
    if (flush_i) begin
      pc_next = flush_pc_i;
    end else if (override_vld_i) begin
      pc_next = override_pc_i;
    end else begin
      pc_next = branch_pc_i;
    end
  end

  // holds while the instruction buffer is full
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc_f0_o <= RESET_PC;
    end else if (fill_i) begin
      pc_f0_o <= pc_next;
    end
  end

endmodule

`default_nettype wire
